/* src/mipsPkg.sv */
package mipsPkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [5:0]  opField_t;

    // instruction field positions
    localparam int OP_MSB = 31;
    localparam int RS_MSB = 25;
    localparam int RT_MSB = 20;
    localparam int RD_MSB = 15;
    localparam int FN_MSB = 5;

    localparam int       NUM_REGS = 32;
    localparam regAddr_t LINK_REG = 5'd31;
    localparam word_t    NOP_INS  = 32'h0000_0000;

    // primary opcodes
    localparam opField_t OP_SPECIAL = 6'h00;
    localparam opField_t OP_JAL     = 6'h03;
    localparam opField_t OP_BEQ     = 6'h04;
    localparam opField_t OP_ADDIU   = 6'h09;
    localparam opField_t OP_ORI     = 6'h0d;
    localparam opField_t OP_LUI     = 6'h0f;
    localparam opField_t OP_LW      = 6'h23;
    localparam opField_t OP_SW      = 6'h2b;

    // funct values under OP_SPECIAL
    localparam opField_t FN_JR   = 6'h08;
    localparam opField_t FN_ADDU = 6'h21;
    localparam opField_t FN_SUBU = 6'h23;
    localparam opField_t FN_OR   = 6'h25;
    localparam opField_t FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        CLS_CALR  = 3'd0,
        CLS_JREG  = 3'd1,
        CLS_CALI  = 3'd2,
        CLS_BEQ   = 3'd3,
        CLS_LOAD  = 3'd4,
        CLS_STORE = 3'd5,
        CLS_JAL   = 3'd6,
        CLS_NOP   = 3'd7
    } insClass_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_M   = 2'd1,
        FWD_W   = 2'd2
    } fwdSel_e;

    // one instruction as the hazard logic sees it, dst is 0 for non-writers
    typedef struct packed {
        insClass_e cls;
        regAddr_t  rs;
        regAddr_t  rt;
        regAddr_t  dst;
        logic      readsRs;
        logic      readsRt;
    } stageInfo_t;

    typedef struct packed {
        logic    holdF;
        logic    holdD;
        logic    holdE;
        logic    bubbleE;
        logic    bubbleM;
        fwdSel_e fwdBranchA;
        fwdSel_e fwdBranchB;
        fwdSel_e fwdAluA;
        fwdSel_e fwdAluB;
        fwdSel_e fwdStoreData;
    } hazardCtrl_t;

endpackage

/* src/insClassify.sv */
`timescale 1ns/100ps

module insClassify
    import mipsPkg::*;
(
    input  word_t      insWord_i,
    output stageInfo_t info_o
);

    opField_t op;
    opField_t fn;

    assign op = insWord_i[OP_MSB -: 6];
    assign fn = insWord_i[FN_MSB -: 6];

    always_comb
    begin
        info_o.cls     = CLS_NOP;
        info_o.rs      = insWord_i[RS_MSB -: 5];
        info_o.rt      = insWord_i[RT_MSB -: 5];
        info_o.dst     = '0;
        info_o.readsRs = 1'b0;
        info_o.readsRt = 1'b0;
        case (op)
            OP_SPECIAL:
            begin
                if (fn inside {FN_ADDU, FN_SUBU, FN_OR, FN_SLT})
                begin
                    info_o.cls     = CLS_CALR;
                    info_o.dst     = insWord_i[RD_MSB -: 5];
                    info_o.readsRs = 1'b1;
                    info_o.readsRt = 1'b1;
                end
                else if (fn == FN_JR)
                begin
                    info_o.cls     = CLS_JREG;
                    info_o.readsRs = 1'b1;
                end
            end
            OP_ORI, OP_ADDIU, OP_LUI:
            begin
                info_o.cls     = CLS_CALI;
                info_o.dst     = insWord_i[RT_MSB -: 5];
                // lui has no register source
                info_o.readsRs = (op != OP_LUI);
            end
            OP_LW:
            begin
                info_o.cls     = CLS_LOAD;
                info_o.dst     = insWord_i[RT_MSB -: 5];
                info_o.readsRs = 1'b1;
            end
            OP_SW:
            begin
                info_o.cls     = CLS_STORE;
                info_o.readsRs = 1'b1;
                info_o.readsRt = 1'b1;
            end
            OP_BEQ:
            begin
                info_o.cls     = CLS_BEQ;
                info_o.readsRs = 1'b1;
                info_o.readsRt = 1'b1;
            end
            OP_JAL:
            begin
                info_o.cls = CLS_JAL;
                info_o.dst = LINK_REG;
            end
            default:
            begin
                info_o.cls = CLS_NOP;
            end
        endcase
    end

endmodule

/* src/hazardUnit.sv */
`timescale 1ns/100ps

module hazardUnit
    import mipsPkg::*;
(
    input  logic        clk_i,
    input  logic        rstN_i,
    input  stageInfo_t  infoD_i,
    input  stageInfo_t  infoE_i,
    input  stageInfo_t  infoM_i,
    input  stageInfo_t  infoW_i,
    output hazardCtrl_t ctrl_o
);

    // match on a real register only
    function automatic logic regHit(regAddr_t src, regAddr_t dst);
        return (src != '0) && (src == dst);
    endfunction

    // execute operand source, the newest producer wins
    function automatic fwdSel_e execSrc(
        logic     used,
        regAddr_t src,
        regAddr_t dstM,
        logic     loadM,
        regAddr_t dstW
    );
        if (!used)
        begin
            return FWD_REG;
        end
        if (regHit(src, dstM))
        begin
            // load data not ready yet, held value gets fixed later
            return loadM ? FWD_REG : FWD_M;
        end
        if (regHit(src, dstW))
        begin
            return FWD_W;
        end
        return FWD_REG;
    endfunction

    logic mLoad;
    logic brUseA;
    logic brUseB;
    logic exUseA;
    logic exUseB;
    logic exAluB;
    logic decStall;
    logic loadUse;

    // ******************************
    // consumers per stage
    // ******************************

    assign mLoad  = (infoM_i.cls == CLS_LOAD);

    // beq and jr resolve in decode
    assign brUseA = infoD_i.readsRs && (infoD_i.cls inside {CLS_BEQ, CLS_JREG});
    assign brUseB = infoD_i.readsRt && (infoD_i.cls == CLS_BEQ);

    // alu operand A, also the load and store address base
    assign exUseA = infoE_i.readsRs && !(infoE_i.cls inside {CLS_BEQ, CLS_JREG});
    // rt feeds the alu or becomes store data
    assign exUseB = infoE_i.readsRt && (infoE_i.cls inside {CLS_CALR, CLS_STORE});
    assign exAluB = infoE_i.readsRt && (infoE_i.cls == CLS_CALR);

    // ******************************
    // stall conditions
    // ******************************

    // branch source still being computed in E, or loaded in M
    assign decStall = (brUseA && regHit(infoD_i.rs, infoE_i.dst))
                   || (brUseB && regHit(infoD_i.rt, infoE_i.dst))
                   || (mLoad && brUseA && regHit(infoD_i.rs, infoM_i.dst))
                   || (mLoad && brUseB && regHit(infoD_i.rt, infoM_i.dst));

    // store data is left out, it is repaired from W in the memory stage
    assign loadUse = mLoad && ((exUseA && regHit(infoE_i.rs, infoM_i.dst))
                            || (exAluB && regHit(infoE_i.rt, infoM_i.dst)));

    always_comb
    begin
        ctrl_o.holdF   = decStall || loadUse;
        ctrl_o.holdD   = decStall || loadUse;
        ctrl_o.holdE   = loadUse;
        ctrl_o.bubbleE = decStall && !loadUse;
        ctrl_o.bubbleM = loadUse;

        // W producers reach decode through the register file bypass
        ctrl_o.fwdBranchA = (brUseA && regHit(infoD_i.rs, infoM_i.dst)) ? FWD_M : FWD_REG;
        ctrl_o.fwdBranchB = (brUseB && regHit(infoD_i.rt, infoM_i.dst)) ? FWD_M : FWD_REG;

        ctrl_o.fwdAluA = execSrc(exUseA, infoE_i.rs, infoM_i.dst, mLoad, infoW_i.dst);
        ctrl_o.fwdAluB = execSrc(exUseB, infoE_i.rt, infoM_i.dst, mLoad, infoW_i.dst);

        ctrl_o.fwdStoreData = FWD_REG;
        if ((infoM_i.cls == CLS_STORE) && regHit(infoM_i.rt, infoW_i.dst))
        begin
            ctrl_o.fwdStoreData = FWD_W;
        end
    end

    // load-use freezes E for exactly one cycle, the load then sits in W
    assert property (@(posedge clk_i) disable iff (!rstN_i)
        ctrl_o.bubbleM |-> ctrl_o.holdE && !ctrl_o.bubbleE ##1 !ctrl_o.bubbleM);

    // register 0 never comes from a later stage
    assert property (@(posedge clk_i) disable iff (!rstN_i)
        (infoD_i.rs != '0 || ctrl_o.fwdBranchA == FWD_REG)
        && (infoD_i.rt != '0 || ctrl_o.fwdBranchB == FWD_REG)
        && (infoE_i.rs != '0 || ctrl_o.fwdAluA == FWD_REG)
        && (infoE_i.rt != '0 || ctrl_o.fwdAluB == FWD_REG)
        && (infoM_i.rt != '0 || ctrl_o.fwdStoreData == FWD_REG));

endmodule

/* src/regFile.sv */
`timescale 1ns/100ps

module regFile
    import mipsPkg::*;
(
    input  logic     clk_i,
    input  logic     rstN_i,
    input  regAddr_t raddrA_i,
    input  regAddr_t raddrB_i,
    output word_t    rdataA_o,
    output word_t    rdataB_o,
    input  logic     we_i,
    input  regAddr_t waddr_i,
    input  word_t    wdata_i
);

    word_t regs [NUM_REGS];
    logic  wrValid;

    // $0 is never written so it reads as zero
    assign wrValid = we_i && (waddr_i != '0);

    always_ff @(posedge clk_i or negedge rstN_i)
    begin
        if (!rstN_i)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wrValid)
        begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-before-read bypass
    assign rdataA_o = (wrValid && (waddr_i == raddrA_i)) ? wdata_i : regs[raddrA_i];
    assign rdataB_o = (wrValid && (waddr_i == raddrB_i)) ? wdata_i : regs[raddrB_i];

endmodule

/* src/pipeDatapath.sv */
`timescale 1ns/100ps

module pipeDatapath
    import mipsPkg::*;
(
    input  logic        clk_i,
    input  logic        rstN_i,
    output word_t       imemAddr_o,
    input  word_t       imemData_i,
    output word_t       dmemAddr_o,
    output word_t       dmemWData_o,
    output logic        dmemWe_o,
    input  word_t       dmemRData_i,
    output word_t       insD_o,
    output word_t       insE_o,
    output word_t       insM_o,
    output word_t       insW_o,
    input  hazardCtrl_t ctrl_i,
    output regAddr_t    rfRaddrA_o,
    output regAddr_t    rfRaddrB_o,
    input  word_t       rfRdataA_i,
    input  word_t       rfRdataB_i,
    output logic        rfWe_o,
    output regAddr_t    rfWaddr_o,
    output word_t       rfWdata_o,
    output logic        wbEn_o,
    output regAddr_t    wbReg_o,
    output word_t       wbData_o
);

    function automatic word_t pickFwd(fwdSel_e sel, word_t held, word_t valM, word_t valW);
        case (sel)
            FWD_M:   return valM;
            FWD_W:   return valW;
            default: return held;
        endcase
    endfunction

    word_t    pcF;
    word_t    pcNext;
    word_t    insD;
    word_t    pcD;
    word_t    insE;
    word_t    pcE;
    word_t    rsValE;
    word_t    rtValE;
    word_t    insM;
    word_t    resM;
    word_t    rtValM;
    word_t    insW;
    word_t    resW;
    word_t    memW;
    word_t    valW;
    regAddr_t dstW;

    // ******************************
    // fetch and decode
    // ******************************

    opField_t opD;
    word_t    brA;
    word_t    brB;
    word_t    pcPlus4D;
    word_t    targetD;
    logic     takenD;

    assign imemAddr_o = pcF;
    assign opD        = insD[OP_MSB -: 6];
    assign rfRaddrA_o = insD[RS_MSB -: 5];
    assign rfRaddrB_o = insD[RT_MSB -: 5];
    assign brA        = pickFwd(ctrl_i.fwdBranchA, rfRdataA_i, resM, valW);
    assign brB        = pickFwd(ctrl_i.fwdBranchB, rfRdataB_i, resM, valW);
    assign pcPlus4D   = pcD + 32'd4;

    // delay slot is already in fetch, so the target goes straight to the PC
    always_comb
    begin
        takenD  = 1'b0;
        targetD = pcPlus4D + {{14{insD[15]}}, insD[15:0], 2'b00};
        if (opD == OP_BEQ)
        begin
            takenD = (brA == brB);
        end
        else if (opD == OP_JAL)
        begin
            takenD  = 1'b1;
            targetD = {pcPlus4D[31:28], insD[25:0], 2'b00};
        end
        else if ((opD == OP_SPECIAL) && (insD[FN_MSB -: 6] == FN_JR))
        begin
            takenD  = 1'b1;
            targetD = brA;
        end
    end

    assign pcNext = takenD ? targetD : pcF + 32'd4;

    // ******************************
    // execute
    // ******************************

    opField_t opE;
    word_t    opA;
    word_t    opB;
    word_t    immSextE;
    word_t    resE;

    assign opE      = insE[OP_MSB -: 6];
    assign opA      = pickFwd(ctrl_i.fwdAluA, rsValE, resM, valW);
    assign opB      = pickFwd(ctrl_i.fwdAluB, rtValE, resM, valW);
    assign immSextE = {{16{insE[15]}}, insE[15:0]};

    always_comb
    begin
        case (opE)
            OP_SPECIAL:
            begin
                case (insE[FN_MSB -: 6])
                    FN_ADDU: resE = opA + opB;
                    FN_SUBU: resE = opA - opB;
                    FN_OR:   resE = opA | opB;
                    FN_SLT:  resE = {31'b0, $signed(opA) < $signed(opB)};
                    default: resE = '0;
                endcase
            end
            OP_ORI:  resE = opA | {16'b0, insE[15:0]};
            OP_LUI:  resE = {insE[15:0], 16'b0};
            OP_JAL:  resE = pcE + 32'd8;
            // addiu, lw and sw share the adder
            default: resE = opA + immSextE;
        endcase
    end

    // ******************************
    // memory and writeback
    // ******************************

    assign dmemAddr_o  = resM;
    assign dmemWData_o = pickFwd(ctrl_i.fwdStoreData, rtValM, resM, valW);
    assign dmemWe_o    = (insM[OP_MSB -: 6] == OP_SW);

    always_comb
    begin
        case (insW[OP_MSB -: 6])
            OP_SPECIAL:
            begin
                dstW = '0;
                if (insW[FN_MSB -: 6] inside {FN_ADDU, FN_SUBU, FN_OR, FN_SLT})
                begin
                    dstW = insW[RD_MSB -: 5];
                end
            end
            OP_ORI, OP_LUI, OP_ADDIU, OP_LW: dstW = insW[RT_MSB -: 5];
            OP_JAL:  dstW = LINK_REG;
            default: dstW = '0;
        endcase
    end

    assign valW      = (insW[OP_MSB -: 6] == OP_LW) ? memW : resW;
    assign wbEn_o    = (dstW != '0);
    assign wbReg_o   = dstW;
    assign wbData_o  = valW;
    assign rfWe_o    = wbEn_o;
    assign rfWaddr_o = dstW;
    assign rfWdata_o = valW;

    assign insD_o = insD;
    assign insE_o = insE;
    assign insM_o = insM;
    assign insW_o = insW;

    // ******************************
    // pipeline registers
    // ******************************

    always_ff @(posedge clk_i or negedge rstN_i)
    begin
        if (!rstN_i)
        begin
            pcF  <= '0;
            insD <= NOP_INS;
            pcD  <= '0;
            insE <= NOP_INS;
            pcE  <= '0;
            insM <= NOP_INS;
            insW <= NOP_INS;
        end
        else
        begin
            if (!ctrl_i.holdF)
            begin
                pcF <= pcNext;
            end
            if (!ctrl_i.holdD)
            begin
                insD <= imemData_i;
                pcD  <= pcF;
            end
            if (ctrl_i.bubbleE)
            begin
                insE <= NOP_INS;
            end
            else if (!ctrl_i.holdE)
            begin
                insE <= insD;
                pcE  <= pcD;
            end
            insM <= ctrl_i.bubbleM ? NOP_INS : insE;
            insW <= insM;
        end
    end

    always_ff @(posedge clk_i)
    begin
        // a held E stage keeps its forwarded operands, W moves on meanwhile
        if (ctrl_i.holdE)
        begin
            rsValE <= opA;
            rtValE <= opB;
        end
        else
        begin
            rsValE <= rfRdataA_i;
            rtValE <= rfRdataB_i;
        end
        resM   <= resE;
        rtValM <= opB;
        resW   <= resM;
        memW   <= dmemRData_i;
    end

    assert property (@(posedge clk_i) disable iff (!rstN_i) pcF[1:0] == 2'b00);

endmodule

/* src/mipsCore.sv */
`timescale 1ns/100ps

module mipsCore
    import mipsPkg::*;
(
    input  logic     clk_i,
    input  logic     rstN_i,
    output word_t    imemAddr_o,
    input  word_t    imemData_i,
    output word_t    dmemAddr_o,
    output word_t    dmemWData_o,
    output logic     dmemWe_o,
    input  word_t    dmemRData_i,
    output logic     wbEn_o,
    output regAddr_t wbReg_o,
    output word_t    wbData_o
);

    // stage order D, E, M, W
    word_t       insStage [4];
    stageInfo_t  info [4];
    hazardCtrl_t ctrl;
    regAddr_t    rfRaddrA;
    regAddr_t    rfRaddrB;
    word_t       rfRdataA;
    word_t       rfRdataB;
    logic        rfWe;
    regAddr_t    rfWaddr;
    word_t       rfWdata;

    pipeDatapath i_pipeDatapath (
        .clk_i       (clk_i),
        .rstN_i      (rstN_i),
        .imemAddr_o  (imemAddr_o),
        .imemData_i  (imemData_i),
        .dmemAddr_o  (dmemAddr_o),
        .dmemWData_o (dmemWData_o),
        .dmemWe_o    (dmemWe_o),
        .dmemRData_i (dmemRData_i),
        .insD_o      (insStage[0]),
        .insE_o      (insStage[1]),
        .insM_o      (insStage[2]),
        .insW_o      (insStage[3]),
        .ctrl_i      (ctrl),
        .rfRaddrA_o  (rfRaddrA),
        .rfRaddrB_o  (rfRaddrB),
        .rfRdataA_i  (rfRdataA),
        .rfRdataB_i  (rfRdataB),
        .rfWe_o      (rfWe),
        .rfWaddr_o   (rfWaddr),
        .rfWdata_o   (rfWdata),
        .wbEn_o      (wbEn_o),
        .wbReg_o     (wbReg_o),
        .wbData_o    (wbData_o)
    );

    for (genvar s = 0; s < 4; s++)
    begin : g_classify
        insClassify i_insClassify (
            .insWord_i (insStage[s]),
            .info_o    (info[s])
        );
    end

    hazardUnit i_hazardUnit (
        .clk_i   (clk_i),
        .rstN_i  (rstN_i),
        .infoD_i (info[0]),
        .infoE_i (info[1]),
        .infoM_i (info[2]),
        .infoW_i (info[3]),
        .ctrl_o  (ctrl)
    );

    regFile i_regFile (
        .clk_i    (clk_i),
        .rstN_i   (rstN_i),
        .raddrA_i (rfRaddrA),
        .raddrB_i (rfRaddrB),
        .rdataA_o (rfRdataA),
        .rdataB_o (rfRdataB),
        .we_i     (rfWe),
        .waddr_i  (rfWaddr),
        .wdata_i  (rfWdata)
    );

endmodule

/* testbench/tbIsaModel.svh */
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

localparam int PROG_LEN   = 96;
localparam int LOOP_IDX   = 104;
localparam int IMEM_WORDS = 128;
localparam int DMEM_WORDS = 64;

typedef struct packed {
    regAddr_t dst;
    word_t    val;
} wbEvent_t;

typedef struct packed {
    word_t addr;
    word_t data;
} storeEvent_t;

word_t       prog [IMEM_WORDS];
word_t       dataInit [DMEM_WORDS];
wbEvent_t    expWb [$];
storeEvent_t expStore [$];
logic [31:0] rngState = 32'h4e8f;

function logic [31:0] xorshift32();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
endfunction

// mostly $0..$4 so dependencies stay dense, sometimes the link register
function regAddr_t pickReg();
    logic [31:0] r;
    r = xorshift32();
    return (r[2:0] == 3'd7) ? LINK_REG : regAddr_t'(r[10:3] % 5);
endfunction

function word_t encR(opField_t fn, regAddr_t rs, regAddr_t rt, regAddr_t rd);
    return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
endfunction

function word_t encI(opField_t op, regAddr_t rs, regAddr_t rt, logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// ******************************
// random program
// ******************************

task automatic buildProgram();
    logic [31:0] r;
    logic        reserved [IMEM_WORDS];
    logic        prevCtl;
    opField_t    aluFn [4];
    opField_t    immOp [3];
    regAddr_t    ra;
    regAddr_t    rb;
    regAddr_t    rc;
    regAddr_t    rj;
    int          i;
    int          n;
    int          kind;
    aluFn = '{FN_ADDU, FN_SUBU, FN_OR, FN_SLT};
    immOp = '{OP_ORI, OP_ADDIU, OP_LUI};
    for (int k = 0; k < IMEM_WORDS; k++)
    begin
        prog[k]     = NOP_INS;
        reserved[k] = 1'b0;
    end
    for (int k = 0; k < DMEM_WORDS; k++)
    begin
        dataInit[k] = 32'hd47a_0000 | word_t'(k << 2);
    end
    // final self-loop, the delay slot behind it stays a nop
    prog[LOOP_IDX] = encI(OP_BEQ, 5'd0, 5'd0, 16'hffff);
    i       = 0;
    prevCtl = 1'b0;
    while (i < PROG_LEN)
    begin
        r    = xorshift32();
        ra   = pickReg();
        rb   = pickReg();
        rc   = pickReg();
        n    = 1 + int'(r[9:8]);
        kind = int'(r[3:0]);
        // no control transfer in a delay slot
        if (prevCtl)
        begin
            kind = kind % 11;
        end
        prevCtl = 1'b0;
        case (kind)
            0, 1, 2, 3: prog[i] = encR(aluFn[r[5:4]], ra, rb, rc);
            4, 5, 6:    prog[i] = encI(immOp[r[5:4] % 3], ra, rb, r[31:16]);
            7, 8:       prog[i] = encI(OP_LW, ra, rb, {8'd0, r[21:16], 2'b00});
            9, 10:      prog[i] = encI(OP_SW, ra, rb, {8'd0, r[21:16], 2'b00});
            11, 12:
            begin
                prog[i]          = encI(OP_BEQ, ra, rb, 16'(n));
                reserved[i+1+n] = 1'b1;
                prevCtl          = 1'b1;
            end
            13:
            begin
                prog[i]          = {OP_JAL, 26'(i + 1 + n)};
                reserved[i+1+n] = 1'b1;
                prevCtl          = 1'b1;
            end
            14:
            begin
                // ori loads a forward target right before jr, nothing may land on the jr
                if ((i + 1 < PROG_LEN) && !reserved[i+1])
                begin
                    rj               = regAddr_t'(1 + r[7:6]);
                    prog[i]          = encI(OP_ORI, 5'd0, rj, 16'((i + 2 + n) * 4));
                    prog[i+1]        = encR(FN_JR, rj, 5'd0, 5'd0);
                    reserved[i+2+n] = 1'b1;
                    prevCtl          = 1'b1;
                    i++;
                end
            end
            default: prog[i] = NOP_INS;
        endcase
        i++;
    end
endtask

// ******************************
// in-order reference model
// ******************************

task automatic runModel();
    word_t    regs [NUM_REGS];
    word_t    mem [DMEM_WORDS];
    word_t    pc;
    word_t    npc;
    word_t    target;
    word_t    ins;
    word_t    imm;
    word_t    addr;
    word_t    res;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t dst;
    int       steps;
    for (int k = 0; k < NUM_REGS; k++)
    begin
        regs[k] = '0;
    end
    mem   = dataInit;
    pc    = '0;
    npc   = 32'd4;
    steps = 0;
    while ((pc != LOOP_IDX * 4) && (steps < 4 * PROG_LEN))
    begin
        ins    = prog[pc[8:2]];
        rs     = ins[RS_MSB -: 5];
        rt     = ins[RT_MSB -: 5];
        imm    = {{16{ins[15]}}, ins[15:0]};
        target = npc + 32'd4;
        dst    = '0;
        res    = '0;
        case (ins[31:26])
            OP_SPECIAL:
            begin
                dst = ins[RD_MSB -: 5];
                case (ins[5:0])
                    FN_ADDU: res = regs[rs] + regs[rt];
                    FN_SUBU: res = regs[rs] - regs[rt];
                    FN_OR:   res = regs[rs] | regs[rt];
                    FN_SLT:  res = ($signed(regs[rs]) < $signed(regs[rt])) ? 32'd1 : 32'd0;
                    FN_JR:
                    begin
                        dst    = '0;
                        target = regs[rs];
                    end
                    default: dst = '0;
                endcase
            end
            OP_ORI:
            begin
                dst = rt;
                res = regs[rs] | {16'h0, ins[15:0]};
            end
            OP_ADDIU:
            begin
                dst = rt;
                res = regs[rs] + imm;
            end
            OP_LUI:
            begin
                dst = rt;
                res = {ins[15:0], 16'h0};
            end
            OP_LW:
            begin
                addr = regs[rs] + imm;
                dst  = rt;
                res  = mem[addr[7:2]];
            end
            OP_SW:
            begin
                // data memory decodes address bits 7:2 only
                addr              = regs[rs] + imm;
                mem[addr[7:2]]    = regs[rt];
                expStore.push_back(storeEvent_t'{addr, regs[rt]});
            end
            OP_BEQ:
            begin
                if (regs[rs] == regs[rt])
                begin
                    target = npc + {imm[29:0], 2'b00};
                end
            end
            OP_JAL:
            begin
                dst    = LINK_REG;
                res    = pc + 32'd8;
                target = {npc[31:28], ins[25:0], 2'b00};
            end
            default: dst = '0;
        endcase
        if (dst != '0)
        begin
            regs[dst] = res;
            expWb.push_back(wbEvent_t'{dst, res});
        end
        pc  = npc;
        npc = target;
        steps++;
    end
endtask

`endif

/* testbench/tbMipsCore.sv */
`timescale 1ns/100ps

module tbMipsCore
    import mipsPkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int DONE_TIMEOUT = 2000;
    localparam int DRAIN_CYCLES = 20;

    logic     clk;
    logic     rstN;
    word_t    imemAddr;
    word_t    imemData;
    word_t    dmemAddr;
    word_t    dmemWData;
    logic     dmemWe;
    word_t    dmemRData;
    logic     wbEn;
    regAddr_t wbReg;
    word_t    wbData;
    int       cycleCnt;
    int       cyclesOut;

    `include "tbIsaModel.svh"

    word_t dmem [DMEM_WORDS];

    mipsCore i_mipsCore (
        .clk_i       (clk),
        .rstN_i      (rstN),
        .imemAddr_o  (imemAddr),
        .imemData_i  (imemData),
        .dmemAddr_o  (dmemAddr),
        .dmemWData_o (dmemWData),
        .dmemWe_o    (dmemWe),
        .dmemRData_i (dmemRData),
        .wbEn_o      (wbEn),
        .wbReg_o     (wbReg),
        .wbData_o    (wbData)
    );

    always
    begin
        #4 clk = ~clk;
    end

    task automatic stopOnError(string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(string name, word_t expected, word_t actual);
        assert (actual === expected)
        else stopOnError($sformatf("Fail at %0t ns: %s expected %h, got %h",
                                   $time, name, expected, actual));
    endtask

    // ******************************
    // output checks
    // ******************************

    task automatic checkStrobes();
        wbEvent_t    wbExp;
        storeEvent_t stExp;
        assert (!$isunknown({wbEn, dmemWe}))
        else stopOnError("a strobe output is unknown after reset");
        if (wbEn === 1'b1)
        begin
            assert (wbReg != '0)
            else stopOnError("writeback strobe names register 0");
            assert (expWb.size() > 0)
            else stopOnError("writeback strobe seen after the last expected register write");
            wbExp = expWb.pop_front();
            checkValue("wbReg_o", word_t'(wbExp.dst), word_t'(wbReg));
            checkValue("wbData_o", wbExp.val, wbData);
        end
        if (dmemWe === 1'b1)
        begin
            assert (expStore.size() > 0)
            else stopOnError("data memory write seen after the last expected store");
            stExp = expStore.pop_front();
            checkValue("dmemAddr_o", stExp.addr, dmemAddr);
            checkValue("dmemWData_o", stExp.data, dmemWData);
        end
    endtask

    // sample first, then update memories and drive for the next rising edge
    always @(negedge clk)
    begin
        if (!rstN || (cyclesOut == 0))
        begin
            checkValue("wbEn_o", '0, word_t'(wbEn));
            checkValue("dmemWe_o", '0, word_t'(dmemWe));
        end
        if (rstN)
        begin
            checkStrobes();
            if (dmemWe === 1'b1)
            begin
                dmem[dmemAddr[7:2]] = dmemWData;
            end
            cyclesOut++;
        end
        imemData  = prog[imemAddr[8:2]];
        dmemRData = dmem[dmemAddr[7:2]];
        cycleCnt++;
        if (cycleCnt >= RESET_CYCLES)
        begin
            rstN = 1'b1;
        end
    end

    initial
    begin
        int waitCycles;
        clk       = 1'b0;
        rstN      = 1'b0;
        imemData  = NOP_INS;
        dmemRData = '0;
        cycleCnt  = 0;
        cyclesOut = 0;
        buildProgram();
        runModel();
        dmem = dataInit;
        waitCycles = 0;
        while (((expWb.size() != 0) || (expStore.size() != 0)) && (waitCycles < DONE_TIMEOUT))
        begin
            @(posedge clk);
            waitCycles++;
        end
        if ((expWb.size() == 0) && (expStore.size() == 0))
        begin
            // keep running a little so a stray extra strobe is still caught
            repeat (DRAIN_CYCLES) @(posedge clk);
            @(negedge clk);
            // fetch ends parked in the final self-loop and its delay slot
            assert ((imemAddr == LOOP_IDX * 4) || (imemAddr == LOOP_IDX * 4 + 4))
            else stopOnError($sformatf("Fail at %0t ns: imemAddr_o expected %h or %h, got %h",
                                       $time, word_t'(LOOP_IDX * 4),
                                       word_t'(LOOP_IDX * 4 + 4), imemAddr));
            $display("all tests passed");
            $finish;
        end
        else
        begin
            stopOnError($sformatf("timeout after %0d cycles, %0d writebacks and %0d stores missing",
                                  waitCycles, expWb.size(), expStore.size()));
        end
    end

endmodule

/* verilog.f */
+incdir+testbench
src/mipsPkg.sv
src/insClassify.sv
src/hazardUnit.sv
src/regFile.sv
src/pipeDatapath.sv
src/mipsCore.sv
testbench/tbMipsCore.sv

/* Bender.yml */
package:
  name: mipsCore

sources:
  - files:
      - src/mipsPkg.sv
      - src/insClassify.sv
      - src/hazardUnit.sv
      - src/regFile.sv
      - src/pipeDatapath.sv
      - src/mipsCore.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tbMipsCore.sv
